//--- source/rom_loader_defines.svh
/*
 * ROM loader widths, sample stage count and hold counts
 */

`ifndef ROM_LOADER_DEFINES_SVH
`define ROM_LOADER_DEFINES_SVH

//////////////////////////////
// Host side widths
//////////////////////////////

// Byte address from the ioctl port
`define IOCTL_ADDR_W 25
// One host transfer is a halfword
`define IOCTL_DATA_W 16

//////////////////////////////
// ROM side widths
//////////////////////////////

`define ROM_DATA_W 32
// Word address, byte address with the low two bits dropped
`define ROM_ADDR_W (`IOCTL_ADDR_W - 2)

//////////////////////////////
// Timing
//////////////////////////////

// Register stages on the ioctl inputs
`define SAMPLE_STAGES 2
// Host wait at the start of each download
`define SETTLE_CYCLES 255
// System reset hold after a download is over
`define RESET_HOLD_CYCLES 255

`endif

//--- source/rom_loader_pkg.sv
/*
 * Shared ROM loader types: halfword, byte and word addresses, ROM word union
 */

package rom_loader_pkg;

`include "rom_loader_defines.svh"

	//////////////////////////////
	// Host side
	//////////////////////////////

	// One halfword as the host sends it
	typedef logic [`IOCTL_DATA_W-1:0] halfword_t;

	// Host byte address
	typedef logic [`IOCTL_ADDR_W-1:0] byte_addr_t;

	//////////////////////////////
	// ROM side
	//////////////////////////////

	// ROM word address
	typedef logic [`ROM_ADDR_W-1:0] word_addr_t;

	// Two halfwords, upper one in the high bits
	typedef struct packed {
		halfword_t upper;
		halfword_t lower;
	} half_pair_t;

	// Packer fills it half by half, memory side takes it whole
	typedef union packed {
		logic [`ROM_DATA_W-1:0] whole;
		half_pair_t             half;
	} rom_word_u;

endpackage

//--- source/rom_loader_ifs.sv
/*
 * Internal buses: capture_if (capture to packer), word_if (packer to write port)
 */

`timescale 1ns/1ps

//////////////////////////////
// Capture to packer
//////////////////////////////

interface capture_if;
	import rom_loader_pkg::*;

	// One pulse per host write
	logic       half_strobe;
	// Halfword and byte address that go with the pulse
	halfword_t  half_data;
	byte_addr_t half_addr;
	// Download flag after the sample stages
	logic       active;

	modport source (
		output half_strobe,
		output half_data,
		output half_addr,
		output active
	);

	modport sink (
		input half_strobe,
		input half_data,
		input half_addr,
		input active
	);
endinterface

//////////////////////////////
// Packer to write port
//////////////////////////////

interface word_if;
	import rom_loader_pkg::*;

	// One pulse per completed word
	logic       word_valid;
	rom_word_u  word_data;
	word_addr_t word_addr;
	// High while the write port has a word pending
	logic       hold;

	modport source (
		output word_valid,
		output word_data,
		output word_addr,
		input  hold
	);

	modport sink (
		input  word_valid,
		input  word_data,
		input  word_addr,
		output hold
	);
endinterface

//--- source/ioctl_capture.sv
/*
 * ioctl_capture: samples the host ioctl signals and finds write strobe edges
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module ioctl_capture (
	input  logic                       clk_sys,
	input  logic                       hardware_reset,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  rom_loader_pkg::byte_addr_t ioctl_addr,
	input  rom_loader_pkg::halfword_t  ioctl_data,
	capture_if.source                  capture
);
	import rom_loader_pkg::*;

	localparam int STAGES = `SAMPLE_STAGES;

	// Strobe history, one bit longer than the data path for the edge test
	logic [STAGES:0]   wr_shift;
	logic [STAGES-1:0] download_shift;
	// Data and address follow the same number of stages
	halfword_t         data_stage [STAGES];
	byte_addr_t        addr_stage [STAGES];

	//////////////////////////////
	// Control stages
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			wr_shift       <= '0;
			download_shift <= '0;
		end else begin
			wr_shift[0]       <= ioctl_wr;
			download_shift[0] <= ioctl_download;
			for (int i = 1; i <= STAGES; i++) begin
				wr_shift[i] <= wr_shift[i-1];
			end
			for (int i = 1; i < STAGES; i++) begin
				download_shift[i] <= download_shift[i-1];
			end
		end
	end

	//////////////////////////////
	// Payload stages
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		data_stage[0] <= ioctl_data;
		addr_stage[0] <= ioctl_addr;
		for (int i = 1; i < STAGES; i++) begin
			data_stage[i] <= data_stage[i-1];
			addr_stage[i] <= addr_stage[i-1];
		end
	end

	// Low to high on the delayed strobe, data of the same age beside it
	assign capture.half_strobe = wr_shift[STAGES-1] & ~wr_shift[STAGES];
	assign capture.half_data   = data_stage[STAGES-1];
	assign capture.half_addr   = addr_stage[STAGES-1];
	assign capture.active      = download_shift[STAGES-1];

endmodule

//--- source/halfword_packer.sv
/*
 * halfword_packer: pairs two host halfwords into one ROM word, lower half first
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module halfword_packer (
	input  logic      clk_sys,
	input  logic      hardware_reset,
	capture_if.sink   capture,
	word_if.source    word
);
	import rom_loader_pkg::*;

	// Phase 0 expects the lower half, phase 1 the upper half
	logic       phase;
	// Strobe seen while the write port was busy
	logic       strobe_pending;
	logic       take;
	logic       valid_q;
	rom_word_u  word_buf;
	word_addr_t addr_buf;

	// Accept only while no write is pending
	assign take = (capture.half_strobe | strobe_pending) & ~word.hold;

	//////////////////////////////
	// Phase and valid
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			phase          <= 1'b0;
			strobe_pending <= 1'b0;
			valid_q        <= 1'b0;
		end else if (!capture.active) begin
			// Download over, a half-filled word is dropped
			phase          <= 1'b0;
			strobe_pending <= 1'b0;
			valid_q        <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (take) begin
				phase          <= ~phase;
				strobe_pending <= 1'b0;
				// Upper half completes the word
				valid_q        <= phase;
			end else if (capture.half_strobe) begin
				strobe_pending <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Word buffer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (take && capture.active) begin
			if (!phase) begin
				word_buf.half.lower <= capture.half_data;
				// Word address is the byte address over four
				addr_buf            <= capture.half_addr[`IOCTL_ADDR_W-1:2];
			end else begin
				word_buf.half.upper <= capture.half_data;
			end
		end
	end

	assign word.word_valid = valid_q;
	assign word.word_data  = word_buf;
	assign word.word_addr  = addr_buf;

endmodule

//--- source/rom_write_port.sv
/*
 * rom_write_port: holds a ROM write until the memory acknowledges it
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module rom_write_port (
	input  logic                       clk_sys,
	input  logic                       hardware_reset,
	input  logic                       active,
	word_if.sink                       word,
	output rom_loader_pkg::word_addr_t rom_addr,
	output logic [`ROM_DATA_W-1:0]     rom_data,
	output logic                       rom_write,
	input  logic                       rom_ack
);

	//////////////////////////////
	// Write request
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			rom_write <= 1'b0;
		end else if (!active) begin
			// End of download cancels a pending write
			rom_write <= 1'b0;
		end else if (word.word_valid) begin
			rom_write <= 1'b1;
		end else if (rom_write && rom_ack) begin
			// Drop one cycle after the ack is seen
			rom_write <= 1'b0;
		end
	end

	//////////////////////////////
	// Address and data
	//////////////////////////////

	// Loaded on each new word and held for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (word.word_valid) begin
			rom_addr <= word.word_addr;
			rom_data <= word.word_data.whole;
		end
	end

	// Back pressure towards packer and host wait
	assign word.hold = rom_write;

endmodule

//--- source/download_sequencer.sv
/*
 * download_sequencer: settle wait at download start, system reset hold, host wait
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module download_sequencer (
	input  logic clk_sys,
	input  logic hardware_reset,
	input  logic ioctl_download,
	input  logic hold,
	output logic ioctl_wait,
	output logic system_reset
);

	localparam int SETTLE_W = $clog2(`SETTLE_CYCLES + 1);
	localparam int RESET_W  = $clog2(`RESET_HOLD_CYCLES + 1);

	// Set once per download so the settle runs only at its start
	logic                download_seen;
	logic                settle;
	logic [SETTLE_W-1:0] settle_count;
	logic [RESET_W-1:0]  reset_count;

	//////////////////////////////
	// Settle period
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			download_seen <= 1'b0;
			settle        <= 1'b0;
			settle_count  <= '0;
		end else if (ioctl_download && !download_seen) begin
			// New download, hold the host off
			download_seen <= 1'b1;
			settle        <= 1'b1;
			settle_count  <= '0;
		end else begin
			if (!ioctl_download) begin
				download_seen <= 1'b0;
			end
			// Flag stays up for SETTLE_CYCLES cycles
			if (settle) begin
				if (settle_count == SETTLE_W'(`SETTLE_CYCLES - 1)) begin
					settle <= 1'b0;
				end else begin
					settle_count <= settle_count + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// System reset hold
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			reset_count <= '0;
		end else if (ioctl_download || settle) begin
			// Restart while loading or settling
			reset_count <= '0;
		end else if (reset_count != RESET_W'(`RESET_HOLD_CYCLES)) begin
			reset_count <= reset_count + 1'b1;
		end
	end

	assign system_reset = (reset_count != RESET_W'(`RESET_HOLD_CYCLES));
	// Host waits during settle and while a word is pending
	assign ioctl_wait   = settle | hold;

endmodule

//--- source/rom_loader.sv
/*
 * rom_loader: top level, ioctl capture, packer, ROM write port, download sequencer
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module rom_loader (
	input  logic                       clk_sys,
	input  logic                       hardware_reset,
	// Host ioctl port
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  rom_loader_pkg::byte_addr_t ioctl_addr,
	input  rom_loader_pkg::halfword_t  ioctl_data,
	output logic                       ioctl_wait,
	// Core reset
	output logic                       system_reset,
	// ROM write port
	output rom_loader_pkg::word_addr_t rom_addr,
	output logic [`ROM_DATA_W-1:0]     rom_data,
	output logic                       rom_write,
	input  logic                       rom_ack
);

	capture_if capture_bus ();
	word_if    word_bus ();

	//////////////////////////////
	// Input, packing, output
	//////////////////////////////

	ioctl_capture i_capture (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.capture        (capture_bus)
	);

	halfword_packer i_packer (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.capture        (capture_bus),
		.word           (word_bus)
	);

	// Sampled download flag cancels a pending write
	rom_write_port i_write_port (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.active         (capture_bus.active),
		.word           (word_bus),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.rom_write      (rom_write),
		.rom_ack        (rom_ack)
	);

	//////////////////////////////
	// Wait and reset control
	//////////////////////////////

	download_sequencer i_sequencer (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.hold           (word_bus.hold),
		.ioctl_wait     (ioctl_wait),
		.system_reset   (system_reset)
	);

endmodule

//--- bench/rom_loader_assertions.sv
/*
 * Concurrent checks on the ROM write handshake and the host wait
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module rom_loader_assertions (
	input logic                   clk_sys,
	input logic                   hardware_reset,
	input logic                   ioctl_wait,
	input logic                   rom_write,
	input logic                   rom_ack,
	input logic [`ROM_ADDR_W-1:0] rom_addr,
	input logic [`ROM_DATA_W-1:0] rom_data
);

	//////////////////////////////
	// ROM write handshake
	//////////////////////////////

	// Address and data frozen until the memory acknowledges
	write_stable: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		rom_write && !rom_ack |=> $stable(rom_addr) && $stable(rom_data))
		else $error("rom_addr or rom_data changed during a pending write");

	// Request drops one cycle after the ack
	write_drop: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		rom_write && rom_ack |=> !rom_write)
		else $error("rom_write still high the cycle after rom_ack");

	// Host is held back while a word is pending
	wait_covers_write: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		rom_write |-> ioctl_wait)
		else $error("ioctl_wait low while rom_write is high");

endmodule

//--- bench/rom_loader_tb.sv
/*
 * ROM loader testbench: clock, watchdog, LFSR, ROM memory model, host and check tasks
 * Directed tests for reset, download start, word packing, ack delays and odd end
 */

`timescale 1ns/1ps

`include "rom_loader_defines.svh"

module rom_loader_tb;

	// Cycle budgets per test
	// Watchdog adds the two hold counts on top
	localparam int ACK_LIMIT     = 16;
	localparam int RESET_BUDGET  = `RESET_HOLD_CYCLES + 16;
	localparam int SETTLE_BUDGET = `SETTLE_CYCLES + 16;
	localparam int PAIR_BUDGET   = 4 * (`SAMPLE_STAGES + 3) + 2 * ACK_LIMIT;
	localparam int PAIR_COUNT    = 8 + 16 + 1 + 1;
	localparam int WATCHDOG_CYCLES = 2 * RESET_BUDGET + 2 * SETTLE_BUDGET
		+ PAIR_COUNT * PAIR_BUDGET + `SETTLE_CYCLES + `RESET_HOLD_CYCLES;

	logic                     clk_sys = 1'b0;
	logic                     hardware_reset;
	logic                     ioctl_download;
	logic                     ioctl_wr;
	logic [`IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [`IOCTL_DATA_W-1:0] ioctl_data;
	logic                     ioctl_wait;
	logic                     system_reset;
	logic [`ROM_ADDR_W-1:0]   rom_addr;
	logic [`ROM_DATA_W-1:0]   rom_data;
	logic                     rom_write;
	logic                     rom_ack;

	logic [31:0]              lfsr_state = 32'h4ac3;
	int                       ack_delay_bits = 0;
	string                    test_name = "none";
	// Writes as the memory model saw them
	logic [`ROM_ADDR_W-1:0]   seen_addr [$];
	logic [`ROM_DATA_W-1:0]   seen_data [$];

	rom_loader i_dut (.*);

	bind rom_loader rom_loader_assertions i_assertions (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_wait     (ioctl_wait),
		.rom_write      (rom_write),
		.rom_ack        (rom_ack),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data)
	);

	// 20 ns period
	always #10 clk_sys = ~clk_sys;

	//////////////////////////////
	// Random bits and reporting
	//////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		$display("Verification failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic expect_equal(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %0h actual %0h", test_name, what, expected, actual);
			abort_run("value mismatch");
		end
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		abort_run("watchdog timeout, the tests did not finish in time");
	end

	//////////////////////////////
	// ROM memory model
	//////////////////////////////

	initial begin : memory_model
		int delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_write) begin
				seen_addr.push_back(rom_addr);
				seen_data.push_back(rom_data);
				expect_equal("ioctl_wait during write", 1'b1, ioctl_wait);
				// 0 to 7 cycles of back pressure when delays are on
				delay = take_bits(ack_delay_bits);
				repeat (delay) @(negedge clk_sys);
				rom_ack = 1'b1;
				@(negedge clk_sys);
				rom_ack = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Host side tasks
	//////////////////////////////

	// Drives one halfword once the host is no longer held off
	task automatic send_halfword(input logic [`IOCTL_ADDR_W-1:0] addr,
		input logic [`IOCTL_DATA_W-1:0] data);
		int waited;
		waited = 0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
			waited++;
			if (waited > ACK_LIMIT) abort_run("ioctl_wait stuck high before a host write");
		end
		expect_equal("system_reset in download", 1'b1, system_reset);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		// Sample stages, packer and write port latency
		repeat (`SAMPLE_STAGES + 3) @(negedge clk_sys);
	endtask

	task automatic wait_host_ready();
		int waited;
		waited = 0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
			waited++;
			if (waited > ACK_LIMIT) abort_run("pending ROM write never completed");
		end
	endtask

	task automatic wait_reset_release(input int limit, output int cycles);
		cycles = 0;
		while (system_reset) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > limit) abort_run("system_reset did not fall in time");
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic check_reset_state();
		int cycles;
		test_name = "reset_state";
		expect_equal("rom_write", 1'b0, rom_write);
		expect_equal("ioctl_wait", 1'b0, ioctl_wait);
		expect_equal("system_reset", 1'b1, system_reset);
		wait_reset_release(RESET_BUDGET, cycles);
		expect_equal("reset hold long enough", 1'b1, cycles >= `RESET_HOLD_CYCLES);
	endtask

	task automatic check_download_start(input string name);
		int high_cycles;
		test_name = name;
		high_cycles = 0;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		expect_equal("ioctl_wait at start", 1'b1, ioctl_wait);
		while (ioctl_wait) begin
			expect_equal("system_reset in settle", 1'b1, system_reset);
			high_cycles++;
			if (high_cycles > SETTLE_BUDGET) abort_run("ioctl_wait did not fall after settle");
			@(negedge clk_sys);
		end
		expect_equal("settle long enough", 1'b1, high_cycles >= `SETTLE_CYCLES);
	endtask

	// Pairs at consecutive byte addresses with the lower half sent first
	task automatic run_pairs(input string name, input logic [`IOCTL_ADDR_W-1:0] base,
		input int pairs, input int delay_bits);
		logic [`IOCTL_DATA_W-1:0] lo [$];
		logic [`IOCTL_DATA_W-1:0] hi [$];
		logic [`IOCTL_ADDR_W-1:0] addr;
		test_name      = name;
		ack_delay_bits = delay_bits;
		seen_addr.delete();
		seen_data.delete();
		for (int i = 0; i < pairs; i++) begin
			lo.push_back(16'(take_bits(16)));
			hi.push_back(16'(take_bits(16)));
		end
		for (int i = 0; i < pairs; i++) begin
			addr = base + 4 * i;
			send_halfword(addr, lo[i]);
			send_halfword(addr + 2, hi[i]);
		end
		wait_host_ready();
		expect_equal("write count", pairs, seen_addr.size());
		for (int i = 0; i < pairs; i++) begin
			addr = base + 4 * i;
			expect_equal("word address", addr / 4, seen_addr[i]);
			expect_equal("word data", {hi[i], lo[i]}, seen_data[i]);
		end
	endtask

	// Half-filled word at the end must not reach the ROM
	task automatic check_odd_end();
		int cycles;
		test_name      = "odd_end";
		ack_delay_bits = 0;
		seen_addr.delete();
		seen_data.delete();
		send_halfword(25'h000400, 16'(take_bits(16)));
		ioctl_download = 1'b0;
		wait_reset_release(RESET_BUDGET, cycles);
		expect_equal("reset hold long enough", 1'b1, cycles >= `RESET_HOLD_CYCLES);
		expect_equal("writes after odd end", 0, seen_addr.size());
		expect_equal("rom_write after end", 1'b0, rom_write);
		// Next download starts with an empty word, so its first pair lands intact
		check_download_start("odd_end_restart");
		run_pairs("odd_end_next_pair", 25'h000500, 1, 0);
	endtask

	initial begin : main_sequence
		hardware_reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		repeat (2) @(negedge clk_sys);
		hardware_reset = 1'b0;
		check_reset_state();
		check_download_start("download_start");
		run_pairs("pairs_fixed_ack", 25'h000100, 8, 0);
		run_pairs("pairs_random_ack", 25'h000200, 16, 3);
		check_odd_end();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+source
source/rom_loader_pkg.sv
source/rom_loader_ifs.sv
source/ioctl_capture.sv
source/halfword_packer.sv
source/rom_write_port.sv
source/download_sequencer.sv
source/rom_loader.sv
bench/rom_loader_assertions.sv
bench/rom_loader_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the ROM loader testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rom_loader_tb -f compile.f \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/Vrom_loader_tb > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation done"
